// File: cache.f
+incdir+.
cache_pkg.sv
cache_if.sv
tagValidStore.sv
lineDataStore.sv
refillCollector.sv
cacheCtrl.sv
cacheTop.sv
cache_assert.sv
cache_tb.sv

// File: cache_tb.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cacheTb import cache_pkg::*; ();

  localparam int waitLimit = 200;

  logic clk;
  logic rst_n;
  logic valid_i;
  addrT addr_i;
  logic addrOk_o;
  logic dataOk_o;
  wordT rdData_o;
  logic cacheRdValid_o;
  addrT cacheAddr_o;
  logic memRdValid_i;
  logic rdLast_i;
  wordT rdData_i;

  // scoreboard state written by the monitor at posedge
  addrT pendAddr [$];
  int   pendCycle [$];
  int   cycle = 0;
  int   acceptCount = 0;
  int   acceptCycle = 0;
  int   doneCount = 0;
  int   lastLatency = 0;
  int   memReqs = 0;
  bit   rdValidSeen = 0;
  addrT expAddr;

  int   errors = 0;
  int   timeouts = 0;
  bit   aborted = 0;

  logic [15:0] stimLfsr = 16'd3;
  logic [15:0] memLfsr = 16'd3;

  // memory model state
  bit   memBusy = 0;
  int   memWait = 0;
  int   beatNum = 0;
  int   memRand;
  addrT memAddr;

  cacheTop i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // 16-bit Galois LFSR for x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic drawBits(inout logic [15:0] state, input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(state[0]);
      state = lfsrStep(state);
    end
  endtask

  // expected memory contents from the word address mixed with a constant
  function automatic wordT memWord(input addrT addr);
    logic [31:0] wordAddr;
    wordAddr = addr >> 3;
    return {wordAddr * 32'h9E37_79B9, wordAddr ^ 32'h5EED_C0DE};
  endfunction

  function automatic addrT makeAddr(input tagT tag, input indexT index, input wordSelT word);
    return {tag, index, word, 3'b000};
  endfunction

  task automatic checkValue(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic reportTimeout(input string what);
    timeouts++;
    aborted = 1;
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, waitLimit);
  endtask

  task automatic waitAccept(input int startAcc, input string what);
    int t;
    t = 0;
    while (acceptCount == startAcc && !aborted && t < waitLimit) begin
      @(negedge clk);
      t++;
    end
    if (acceptCount == startAcc && !aborted) begin
      reportTimeout(what);
    end
  endtask

  task automatic waitDone(input int target, input string what);
    int t;
    t = 0;
    while (doneCount < target && !aborted && t < waitLimit) begin
      @(negedge clk);
      t++;
    end
    if (doneCount < target && !aborted) begin
      reportTimeout(what);
    end
  endtask

  // one request started at a falling edge
  task automatic access(input addrT addr, output bit missed, output int lat);
    int startAcc;
    int startDone;
    int startMem;
    startAcc = acceptCount;
    startDone = doneCount;
    startMem = memReqs;
    valid_i = 1'b1;
    addr_i = addr;
    waitAccept(startAcc, "acceptance of a request");
    valid_i = 1'b0;
    waitDone(startDone + 1, "dataOk_o for a request");
    missed = (memReqs != startMem);
    lat = lastLatency;
  endtask

  // four words of one resident line on consecutive cycles
  task automatic hitBurst(input addrT base);
    int startAcc;
    int startDone;
    int prevCycle;
    startDone = doneCount;
    prevCycle = 0;
    valid_i = 1'b1;
    for (int i = 0; i < `BEATS; i++) begin
      startAcc = acceptCount;
      addr_i = base + addrT'(8 * i);
      waitAccept(startAcc, "acceptance in a hit burst");
      if (i > 0 && !aborted) begin
        checkValue(acceptCycle, prevCycle + 1, "back-to-back acceptance");
      end
      prevCycle = acceptCycle;
    end
    valid_i = 1'b0;
    waitDone(startDone + `BEATS, "dataOk_o for a hit burst");
  endtask

  // compare process checks data before the same edge's new request is queued
  always @(posedge clk) begin
    if (rst_n) begin
      cycle++;
      if (cacheRdValid_o && !rdValidSeen) begin
        memReqs++;
      end
      rdValidSeen = cacheRdValid_o;
      if (dataOk_o) begin
        if (pendAddr.size() == 0) begin
          errors++;
          $display("dataOk_o pulsed at %0t with no request outstanding", $time);
        end else begin
          expAddr = pendAddr.pop_front();
          lastLatency = cycle - pendCycle.pop_front();
          checkValue(rdData_o, memWord(expAddr), "read data");
          doneCount++;
        end
      end
      if (addrOk_o) begin
        pendAddr.push_back(addr_i);
        pendCycle.push_back(cycle);
        acceptCycle = cycle;
        acceptCount++;
      end
    end
  end

  // memory model with a random start delay and four beats with short gaps
  always @(negedge clk) begin
    memRdValid_i = 1'b0;
    rdLast_i = 1'b0;
    if (!rst_n) begin
      memBusy = 0;
    end else if (!memBusy) begin
      if (cacheRdValid_o) begin
        if (pendAddr.size() == 0) begin
          errors++;
          $display("Memory read at %0t with no request outstanding", $time);
        end else begin
          checkValue(cacheAddr_o, pendAddr[0] & ~addrT'(`LINE_W / 8 - 1),
                     "memory request address");
        end
        memAddr = cacheAddr_o;
        beatNum = 0;
        drawBits(memLfsr, 3, memRand);
        memWait = memRand % 6 + 1;
        memBusy = 1;
      end
    end else if (memWait > 0) begin
      memWait--;
    end else begin
      memRdValid_i = 1'b1;
      rdData_i = memWord(memAddr + addrT'(8 * beatNum));
      rdLast_i = (beatNum == `BEATS - 1);
      beatNum++;
      if (beatNum == `BEATS) begin
        memBusy = 0;
      end else begin
        drawBits(memLfsr, 2, memRand);
        memWait = memRand % 3;
      end
    end
  end

  initial begin
    addrT lineA;
    addrT lineB;
    addrT lineC;
    bit   missed;
    bit   missA;
    bit   missB;
    int   lat;
    int   tagSel;
    int   idxSel;
    int   wordSel;
    int   lineNum;
    bit   seenLine [32];
    valid_i = 1'b0;
    addr_i = '0;
    memRdValid_i = 1'b0;
    rdLast_i = 1'b0;
    rdData_i = '0;
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // quiet after reset and the first access misses
    checkValue(dataOk_o, 0, "dataOk_o after reset");
    checkValue(cacheRdValid_o, 0, "cacheRdValid_o after reset");
    lineA = makeAddr(21'h0ABCD, 6'd1, 2'd2);
    access(lineA, missed, lat);
    checkValue(missed, 1, "first access memory request");

    // repeat hit in one cycle without memory traffic
    access(lineA, missed, lat);
    checkValue(missed, 0, "repeat access memory request");
    checkValue(lat, 1, "hit latency");
    hitBurst(makeAddr(21'h0ABCD, 6'd1, 2'd0));

    // three lines sharing index 5
    lineA = makeAddr(21'h00011, 6'd5, 2'd0);
    lineB = makeAddr(21'h00022, 6'd5, 2'd1);
    lineC = makeAddr(21'h00033, 6'd5, 2'd3);
    access(lineA, missed, lat);
    checkValue(missed, 1, "first fill of set 5");
    access(lineB, missed, lat);
    checkValue(missed, 1, "second fill of set 5");
    access(lineA, missed, lat);
    checkValue(missed, 0, "first line still resident");
    access(lineB, missed, lat);
    checkValue(missed, 0, "second line still resident");
    access(lineC, missed, lat);
    checkValue(missed, 1, "third line of set 5");
    access(lineA, missA, lat);
    access(lineB, missB, lat);
    checkValue(missA || missB, 1, "one of the first two lines evicted");

    // random mix of four tags over indices 8 to 15
    repeat (200) begin
      drawBits(stimLfsr, 2, tagSel);
      drawBits(stimLfsr, 3, idxSel);
      drawBits(stimLfsr, 2, wordSel);
      lineNum = tagSel * 8 + idxSel;
      access(makeAddr(tagT'(32'h100 + tagSel), indexT'(8 + idxSel), wordSelT'(wordSel)),
             missed, lat);
      if (!seenLine[lineNum]) begin
        checkValue(missed, 1, "first access to a random line");
      end
      if (!missed) begin
        checkValue(lat, 1, "hit latency in the random mix");
      end
      seenLine[lineNum] = 1'b1;
    end

    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             errors, timeouts, i_dut.i_assert.failCount);
    if (errors == 0 && timeouts == 0 && i_dut.i_assert.failCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: cache_assert.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cacheAssert import cache_pkg::*; (
  input logic clk,
  input logic rst_n,
  input logic addrOk_o,
  input logic dataOk_o,
  input logic cacheRdValid_o,
  input addrT cacheAddr_o,
  input logic rdLast_i
);

  logic [3:0] pendCnt;
  int         failCount = 0;

  // accepted requests still waiting for dataOk_o
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pendCnt <= '0;
    end else begin
      pendCnt <= pendCnt + 4'(addrOk_o) - 4'(dataOk_o);
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) dataOk_o |-> pendCnt != 0)
    else begin
      failCount++;
      $error("dataOk_o with no request outstanding");
    end

  // memory read level holds until the last beat
  assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o && !rdLast_i |=> cacheRdValid_o)
    else begin
      failCount++;
      $error("cacheRdValid_o dropped before rdLast_i");
    end

  assert property (@(posedge clk) disable iff (!rst_n) cacheRdValid_o |-> !addrOk_o)
    else begin
      failCount++;
      $error("addrOk_o high during a memory read");
    end

  // read address stays line-aligned and steady while the read is up
  assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o |-> cacheAddr_o[`OFFSET_W-1:0] == '0 &&
      (!$past(cacheRdValid_o) || $stable(cacheAddr_o)))
    else begin
      failCount++;
      $error("cacheAddr_o not line-aligned or changed during a read");
    end

endmodule

bind cacheTop cacheAssert i_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .addrOk_o       (addrOk_o),
  .dataOk_o       (dataOk_o),
  .cacheRdValid_o (cacheRdValid_o),
  .cacheAddr_o    (cacheAddr_o),
  .rdLast_i       (rdLast_i)
);

// File: cacheTop.sv
`timescale 1ns/1ps

module cacheTop import cache_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  // pipeline
  input  logic valid_i,
  input  addrT addr_i,
  output logic addrOk_o,
  output logic dataOk_o,
  output wordT rdData_o,
  // memory
  output logic cacheRdValid_o,
  output addrT cacheAddr_o,
  input  logic memRdValid_i,
  input  logic rdLast_i,
  input  wordT rdData_i
);

  lookupIf lk ();
  refillIf rf ();

  logic    dataRdEn;
  indexT   dataRdIndex;
  wordSelT dataWordSel;
  logic    dataWrEn;
  wayT     dataWrWay;
  wordT    wordWay0;
  wordT    wordWay1;

  cacheCtrl i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .rdData_o       (rdData_o),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .rdLast_i       (rdLast_i),
    .lk             (lk.ctrl),
    .rf             (rf.sink),
    .dataRdEn_o     (dataRdEn),
    .dataRdIndex_o  (dataRdIndex),
    .dataWordSel_o  (dataWordSel),
    .dataWrEn_o     (dataWrEn),
    .dataWrWay_o    (dataWrWay),
    .wordWay0_i     (wordWay0),
    .wordWay1_i     (wordWay1)
  );

  tagValidStore i_tagStore (
    .clk   (clk),
    .rst_n (rst_n),
    .lk    (lk.store)
  );

  // fill index comes straight from the lookup interface
  lineDataStore i_dataStore (
    .clk        (clk),
    .rdEn_i     (dataRdEn),
    .rdIndex_i  (dataRdIndex),
    .wordSel_i  (dataWordSel),
    .wrEn_i     (dataWrEn),
    .wrWay_i    (dataWrWay),
    .wrIndex_i  (lk.fillIndex),
    .rf         (rf.sink),
    .wordWay0_o (wordWay0),
    .wordWay1_o (wordWay1)
  );

  refillCollector i_collector (
    .clk          (clk),
    .rst_n        (rst_n),
    .memRdValid_i (memRdValid_i),
    .rdLast_i     (rdLast_i),
    .rdData_i     (rdData_i),
    .rf           (rf.collector)
  );

endmodule

// File: cacheCtrl.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cacheCtrl import cache_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // pipeline side
  input  logic    valid_i,
  input  addrT    addr_i,
  output logic    addrOk_o,
  output logic    dataOk_o,
  output wordT    rdData_o,
  // memory side
  output logic    cacheRdValid_o,
  output addrT    cacheAddr_o,
  input  logic    rdLast_i,
  // tag store and refill line
  lookupIf.ctrl   lk,
  refillIf.sink   rf,
  // line data store
  output logic    dataRdEn_o,
  output indexT   dataRdIndex_o,
  output wordSelT dataWordSel_o,
  output logic    dataWrEn_o,
  output wayT     dataWrWay_o,
  input  wordT    wordWay0_i,
  input  wordT    wordWay1_i
);

  ctrlStateT state;
  ctrlStateT nextState;
  addrT      reqAddr;
  tagT       reqTag;
  indexT     reqIndex;
  wordSelT   reqWordSel;
  indexT     inIndex;
  wordSelT   inWordSel;
  logic      accept;
  logic      replay;
  logic      rdPending;

  // fields of the latched request
  assign reqTag     = reqAddr[`ADDR_W-1 -: `TAG_W];
  assign reqIndex   = reqAddr[`OFFSET_W +: `INDEX_W];
  assign reqWordSel = reqAddr[`OFFSET_W-1 -: $bits(wordSelT)];

  // fields of the incoming request
  assign inIndex   = addr_i[`OFFSET_W +: `INDEX_W];
  assign inWordSel = addr_i[`OFFSET_W-1 -: $bits(wordSelT)];

  // accept in IDLE or in COMPARE while the current one hits
  assign accept   = valid_i && (state == IDLE || (state == COMPARE && lk.hit));
  assign addrOk_o = accept;
  assign replay   = (state == REPLAY);

  assign dataOk_o = (state == COMPARE) && lk.hit;
  assign rdData_o = (lk.hitWay == 1'b1) ? wordWay1_i : wordWay0_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (valid_i) begin
          nextState = COMPARE;
        end
      end
      COMPARE: begin
        if (!lk.hit) begin
          nextState = MISS;
        end else if (!valid_i) begin
          nextState = IDLE;
        end
      end
      MISS: begin
        // a stray lineDone outside MISS is ignored
        if (rf.lineDone) begin
          nextState = REFILL;
        end
      end
      REFILL:  nextState = REPLAY;
      REPLAY:  nextState = COMPARE;
      default: nextState = IDLE;
    endcase
  end

  // request held through miss and replay
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // memory read level is up from the cycle after COMPARE until the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdPending <= 1'b0;
    end else if (state == COMPARE && !lk.hit) begin
      rdPending <= 1'b1;
    end else if (rdLast_i) begin
      rdPending <= 1'b0;
    end
  end

  assign cacheRdValid_o = rdPending;
  assign cacheAddr_o    = {reqTag, reqIndex, {`OFFSET_W{1'b0}}};

  // lookup of a new request or of the latched one after a fill
  assign lk.lookupEn    = accept || replay;
  assign lk.lookupIndex = replay ? reqIndex : inIndex;
  assign lk.compareTag  = reqTag;

  assign lk.fillEn    = (state == REFILL);
  assign lk.fillIndex = reqIndex;
  assign lk.fillTag   = reqTag;

  // data read runs alongside the tag lookup
  assign dataRdEn_o    = accept || replay;
  assign dataRdIndex_o = replay ? reqIndex : inIndex;
  assign dataWordSel_o = replay ? reqWordSel : inWordSel;
  assign dataWrEn_o    = (state == REFILL);
  assign dataWrWay_o   = lk.victimWay;

endmodule

// File: refillCollector.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module refillCollector import cache_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       memRdValid_i,
  input  logic       rdLast_i,
  input  wordT       rdData_i,
  refillIf.collector rf
);

  logic [1:0] beatCnt;
  logic       doneQ;
  logic       lastBeat;
  lineT       lineQ;

  // last beat only counts if the burst had all four beats
  assign lastBeat = memRdValid_i && rdLast_i && (beatCnt == 2'(`BEATS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
      doneQ   <= 1'b0;
    end else begin
      doneQ <= lastBeat;
      if (memRdValid_i) begin
        // rdLast_i also realigns the count after a short burst
        if (rdLast_i) begin
          beatCnt <= '0;
        end else begin
          beatCnt <= beatCnt + 2'd1;
        end
      end
    end
  end

  // beats enter at the top and move down,
  // so beat 0 ends up in the lowest word
  always_ff @(posedge clk) begin
    if (memRdValid_i) begin
      lineQ <= {rdData_i, lineQ[`LINE_W-1:`XLEN]};
    end
  end

  assign rf.lineDone = doneQ;
  assign rf.line     = lineQ;

endmodule

// File: lineDataStore.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module lineDataStore import cache_pkg::*; (
  input  logic    clk,
  input  logic    rdEn_i,
  input  indexT   rdIndex_i,
  input  wordSelT wordSel_i,
  input  logic    wrEn_i,
  input  wayT     wrWay_i,
  input  indexT   wrIndex_i,
  refillIf.sink   rf,
  output wordT    wordWay0_o,
  output wordT    wordWay1_o
);

  localparam int numSets = 1 << `INDEX_W;

  wordSelT wordSelQ;
  wordT    wordOut [2];

  // word select follows the read by one cycle
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      wordSelQ <= wordSel_i;
    end
  end

  for (genvar w = 0; w < 2; w++) begin : g_way
    lineT lineMem [numSets];
    lineT rdLine;

    // stands in for a single-port SRAM macro
    always_ff @(posedge clk) begin
      if (wrEn_i && wrWay_i == wayT'(w)) begin
        lineMem[wrIndex_i] <= rf.line;
      end
      if (rdEn_i) begin
        rdLine <= lineMem[rdIndex_i];
      end
    end

    assign wordOut[w] = rdLine[wordSelQ*`XLEN +: `XLEN];
  end

  assign wordWay0_o = wordOut[0];
  assign wordWay1_o = wordOut[1];

endmodule

// File: tagValidStore.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module tagValidStore import cache_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  lookupIf.store lk
);

  localparam int numSets = 1 << `INDEX_W;

  logic [1:0] wayValid;
  logic [1:0] wayHit;
  logic [7:0] lfsr;

  for (genvar w = 0; w < 2; w++) begin : g_way
    tagT                tagArr [numSets];
    logic [numSets-1:0] validBits;
    tagT                tagQ;
    logic               validQ;

    // valid bits start clear so every first access misses
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        validBits <= '0;
        validQ    <= 1'b0;
      end else begin
        if (lk.fillEn && lk.victimWay == wayT'(w)) begin
          validBits[lk.fillIndex] <= 1'b1;
        end
        if (lk.lookupEn) begin
          validQ <= validBits[lk.lookupIndex];
        end
      end
    end

    always_ff @(posedge clk) begin
      if (lk.fillEn && lk.victimWay == wayT'(w)) begin
        tagArr[lk.fillIndex] <= lk.fillTag;
      end
      if (lk.lookupEn) begin
        tagQ <= tagArr[lk.lookupIndex];
      end
    end

    assign wayValid[w] = validQ;
    assign wayHit[w]   = validQ && (tagQ == lk.compareTag);
  end

  assign lk.hit    = |wayHit;
  assign lk.hitWay = wayT'(wayHit[1]);

  // prefer an empty way before the LFSR pick
  assign lk.victimWay = !wayValid[0] ? 1'b0 :
                        !wayValid[1] ? 1'b1 : lfsr[0];

  // 8-bit Galois LFSR for x^8+x^6+x^5+x^4+1 stepped once per fill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= 8'hE1;
    end else if (lk.fillEn) begin
      lfsr <= (lfsr >> 1) ^ (lfsr[0] ? 8'hB8 : 8'h00);
    end
  end

endmodule

// File: cache_if.sv
`timescale 1ns/1ps

// lookup and fill path between controller and tag store
interface lookupIf import cache_pkg::*; ();

  logic  lookupEn;
  indexT lookupIndex;
  tagT   compareTag;
  logic  fillEn;
  indexT fillIndex;
  tagT   fillTag;

  // combinational answers from the registered set
  logic  hit;
  wayT   hitWay;
  wayT   victimWay;

  modport ctrl (
    output lookupEn, lookupIndex, compareTag,
    output fillEn, fillIndex, fillTag,
    input  hit, hitWay, victimWay
  );

  modport store (
    input  lookupEn, lookupIndex, compareTag,
    input  fillEn, fillIndex, fillTag,
    output hit, hitWay, victimWay
  );

endinterface

// assembled refill line with a one-cycle pulse when complete
interface refillIf import cache_pkg::*; ();

  logic lineDone;
  lineT line;

  modport collector (
    output lineDone, line
  );

  modport sink (
    input lineDone, line
  );

endinterface

// File: cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

  // address and its fields
  typedef logic [`ADDR_W-1:0] addrT;
  typedef logic [`TAG_W-1:0] tagT;
  typedef logic [`INDEX_W-1:0] indexT;

  // payload widths
  typedef logic [`XLEN-1:0] wordT;
  typedef logic [`LINE_W-1:0] lineT;

  // word position inside a line from address bits 4:3
  typedef logic [1:0] wordSelT;

  // two ways per set
  typedef logic [0:0] wayT;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    MISS,
    REFILL,
    REPLAY
  } ctrlStateT;

endpackage

// File: cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// request address width
`define ADDR_W 32

// pipeline data word
`define XLEN 64

// address split into tag, index and offset
`define TAG_W 21
`define INDEX_W 6
`define OFFSET_W 5

// one cache line and the beats that fill it
`define LINE_W 256
`define BEATS 4

`endif
